// File: src/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

	// datapath and instruction field widths
	localparam int DATA_W    = 16;
	localparam int OP_W      = 4;
	localparam int REG_IDX_W = 3;
	localparam int IMM_W     = 8;
	localparam int PC_W      = 4;

	// opcodes, anything not listed decodes as a no-op
	localparam logic [OP_W-1:0] OP_LOAD = 4'b0001;
	localparam logic [OP_W-1:0] OP_ADD  = 4'b0010;
	localparam logic [OP_W-1:0] OP_SUB  = 4'b0011;
	localparam logic [OP_W-1:0] OP_JMP  = 4'b1000;
	localparam logic [OP_W-1:0] OP_ADDI = 4'b1010;
	localparam logic [OP_W-1:0] OP_SUBI = 4'b1011;
	localparam logic [OP_W-1:0] OP_BR   = 4'b1100;
	localparam logic [OP_W-1:0] OP_MOV  = 4'b1110;
	localparam logic [OP_W-1:0] OP_OUT  = 4'b1111;

	// register-register form: add, sub, mov, out
	typedef struct packed {
		logic [OP_W-1:0]                    opcode;
		logic [REG_IDX_W-1:0]               reg_a;
		logic [REG_IDX_W-1:0]               reg_b;
		logic [DATA_W-OP_W-2*REG_IDX_W-1:0] unused;
	} instr_rr_t;

	// register-immediate form: load, addi, subi
	typedef struct packed {
		logic [OP_W-1:0]                        opcode;
		logic [REG_IDX_W-1:0]                   reg_a;
		logic [DATA_W-OP_W-REG_IDX_W-IMM_W-1:0] unused;
		logic [IMM_W-1:0]                       imm;
	} instr_ri_t;

	// jump form: jmp and br share the target field
	typedef struct packed {
		logic [OP_W-1:0]             opcode;
		logic [PC_W-1:0]             target;
		logic [DATA_W-OP_W-PC_W-1:0] unused;
	} instr_jmp_t;

	// one instruction word, viewed per format
	typedef union packed {
		instr_rr_t  rr;
		instr_ri_t  ri;
		instr_jmp_t jmp;
	} instr_t;

endpackage

`default_nettype wire

// File: src/cpu_cfg_pkg.sv
`default_nettype none

package cpu_cfg_pkg;

	// program memory size, one word per pc value
	localparam int ROM_DEPTH = 16;

	// clocks per executed instruction
	localparam int STEP_CYCLES = 4;
	// step counter width
	localparam int STEP_W = $clog2(STEP_CYCLES);

	// low byte of reg_a carried in the result word
	localparam int OUT_DATA_W = 8;

	// program load port
	typedef struct packed {
		logic                           we;
		logic [cpu_isa_pkg::PC_W-1:0]   addr;
		cpu_isa_pkg::instr_t            data;
	} prog_write_t;

	// word emitted by out: {pc of the out, zero pad, low byte}
	typedef struct packed {
		logic [cpu_isa_pkg::PC_W-1:0]                               pc;
		logic [cpu_isa_pkg::DATA_W-cpu_isa_pkg::PC_W-OUT_DATA_W-1:0] rsvd;
		logic [OUT_DATA_W-1:0]                                      data;
	} out_word_t;

endpackage

`default_nettype wire

// File: src/prog_mem.sv
`timescale 1ns/1ps
`default_nettype none

module prog_mem (
	input  wire logic                         clk,
	input  wire cpu_cfg_pkg::prog_write_t     prog,
	input  wire logic [cpu_isa_pkg::PC_W-1:0] pc,
	output cpu_isa_pkg::instr_t               instr
);

	import cpu_isa_pkg::*;
	import cpu_cfg_pkg::*;

	// instruction storage, contents survive reset
	instr_t mem [ROM_DEPTH];

	// load port, writes whenever the strobe is up
	always_ff @(posedge clk) begin
		if (prog.we) begin
			mem[prog.addr] <= prog.data;
		end
	end

	// fetch, no clock in the read path
	assign instr = mem[pc];

	// a strobed write must name a real word
	// otherwise the wrong slot is silently overwritten
	a_addr_known : assert property (
		@(posedge clk) prog.we |-> !$isunknown(prog.addr)
	) else $error("prog_mem: write strobe with unknown address");

endmodule

`default_nettype wire

// File: src/cpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile (
	input  wire logic                                clk,
	input  wire logic                                reset,
	input  wire logic [cpu_isa_pkg::REG_IDX_W-1:0]   addr_a,
	input  wire logic [cpu_isa_pkg::REG_IDX_W-1:0]   addr_b,
	input  wire logic                                write_en,
	input  wire logic [cpu_isa_pkg::DATA_W-1:0]      write_data,
	output logic [cpu_isa_pkg::DATA_W-1:0]           data_a,
	output logic [cpu_isa_pkg::DATA_W-1:0]           data_b
);

	import cpu_isa_pkg::*;

	localparam int NUM_REGS = 2 ** REG_IDX_W;

	logic [DATA_W-1:0] regs [NUM_REGS];

	// destination is always reg_a, so the write index is addr_a
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[addr_a] <= write_data;
		end
	end

	// two read ports, combinational
	assign data_a = regs[addr_a];
	assign data_b = regs[addr_b];

	// an X enable would corrupt an unknown register
	// core drives it from the step counter and decode
	a_we_known : assert property (
		@(posedge clk) disable iff (reset) !$isunknown(write_en)
	) else $error("cpu_regfile: write enable unknown");

endmodule

`default_nettype wire

// File: src/cpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
	input  wire cpu_isa_pkg::instr_t              instr,
	input  wire logic [cpu_isa_pkg::DATA_W-1:0]   data_a,
	input  wire logic [cpu_isa_pkg::DATA_W-1:0]   data_b,
	output logic [cpu_isa_pkg::DATA_W-1:0]        alu_result,
	output logic                                  alu_zero
);

	import cpu_isa_pkg::*;

	logic [DATA_W-1:0] operand_b;
	logic [DATA_W-1:0] imm_ext;
	logic              use_imm;
	logic              do_sub;

	// immediate is unsigned, zero fill the top
	assign imm_ext = {{(DATA_W-IMM_W){1'b0}}, instr.ri.imm};

	// local decode of the four arithmetic ops
	always_comb begin
		use_imm = 1'b0;
		do_sub  = 1'b0;
		case (instr.rr.opcode)
			OP_ADD: begin
				use_imm = 1'b0;
				do_sub  = 1'b0;
			end
			OP_ADDI: begin
				use_imm = 1'b1;
				do_sub  = 1'b0;
			end
			OP_SUB: begin
				use_imm = 1'b0;
				do_sub  = 1'b1;
			end
			OP_SUBI: begin
				use_imm = 1'b1;
				do_sub  = 1'b1;
			end
			// other opcodes, result not consumed
			default: begin
				use_imm = 1'b0;
				do_sub  = 1'b0;
			end
		endcase
	end

	assign operand_b = use_imm ? imm_ext : data_b;

	// wraps at 16 bits
	assign alu_result = do_sub ? (data_a - operand_b) : (data_a + operand_b);
	assign alu_zero   = (alu_result == '0);

endmodule

`default_nettype wire

// File: src/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
	input  wire logic                                clk,
	input  wire logic                                reset,
	input  wire logic                                run,
	input  wire cpu_isa_pkg::instr_t                 instr,
	input  wire logic [cpu_isa_pkg::DATA_W-1:0]      data_a,
	input  wire logic [cpu_isa_pkg::DATA_W-1:0]      data_b,
	input  wire logic [cpu_isa_pkg::DATA_W-1:0]      alu_result,
	input  wire logic                                alu_zero,
	output logic [cpu_isa_pkg::PC_W-1:0]             pc,
	output logic [cpu_isa_pkg::REG_IDX_W-1:0]        addr_a,
	output logic [cpu_isa_pkg::REG_IDX_W-1:0]        addr_b,
	output logic                                     write_en,
	output logic [cpu_isa_pkg::DATA_W-1:0]           write_data,
	output cpu_cfg_pkg::out_word_t                   result,
	output logic                                     result_valid
);

	import cpu_isa_pkg::*;
	import cpu_cfg_pkg::*;

	logic [STEP_W-1:0] step_cnt;
	logic              step;
	logic [OP_W-1:0]   opcode;
	logic              wr_req;
	logic [PC_W-1:0]   pc_inc;
	logic [PC_W-1:0]   pc_next;
	logic              zero_flag;
	logic              is_sub;

	// step divider
	// one execute edge every STEP_CYCLES clocks while running
	assign step = run && (step_cnt == STEP_W'(STEP_CYCLES - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			step_cnt <= '0;
		end else if (!run || step) begin
			step_cnt <= '0;
		end else begin
			step_cnt <= step_cnt + 1'b1;
		end
	end

	// reg_a sits in the same bits in rr and ri
	assign opcode = instr.rr.opcode;
	assign addr_a = instr.rr.reg_a;
	assign addr_b = instr.rr.reg_b;

	// only sub and subi touch the zero flag
	assign is_sub = (opcode == OP_SUB) || (opcode == OP_SUBI);

	// write-back source select
	always_comb begin
		wr_req     = 1'b0;
		write_data = alu_result;
		case (opcode)
			OP_LOAD: begin
				wr_req     = 1'b1;
				write_data = {{(DATA_W-IMM_W){1'b0}}, instr.ri.imm};
			end
			OP_ADD, OP_ADDI, OP_SUB, OP_SUBI: begin
				wr_req     = 1'b1;
				write_data = alu_result;
			end
			OP_MOV: begin
				wr_req     = 1'b1;
				write_data = data_b;
			end
			default: begin
				wr_req     = 1'b0;
				write_data = alu_result;
			end
		endcase
	end

	// register write lands on the step edge itself
	assign write_en = step && wr_req;

	// next pc
	// PC_W bits cover ROM_DEPTH exactly, so +1 wraps 15 to 0
	assign pc_inc = pc + 1'b1;

	always_comb begin
		pc_next = pc_inc;
		case (opcode)
			OP_JMP: pc_next = instr.jmp.target;
			OP_BR: begin
				// taken only on a set flag
				if (zero_flag) begin
					pc_next = instr.jmp.target;
				end
			end
			default: pc_next = pc_inc;
		endcase
	end

	// pc, zero flag and result all update on the step edge
	always_ff @(posedge clk) begin
		if (reset) begin
			pc           <= '0;
			zero_flag    <= 1'b0;
			result       <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= 1'b0;
			if (step) begin
				pc <= pc_next;
				if (is_sub) begin
					zero_flag <= alu_zero;
				end
				if (opcode == OP_OUT) begin
					// address of the out itself rather than pc + 1
					result.pc    <= pc;
					result.rsvd  <= '0;
					result.data  <= data_a[OUT_DATA_W-1:0];
					result_valid <= 1'b1;
				end
			end
		end
	end

	// a result pulse only follows a wrap of the step divider
	a_valid_on_step : assert property (
		@(posedge clk) disable iff (reset)
		result_valid |-> (step_cnt == '0) && $past(step_cnt == STEP_W'(STEP_CYCLES - 1))
	) else $error("cpu_core: result_valid outside a step edge");

	// pc never leaves the program memory
	a_pc_in_range : assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(pc) && (pc < ROM_DEPTH)
	) else $error("cpu_core: pc out of range");

endmodule

`default_nettype wire

// File: src/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input  wire logic                         clk,
	input  wire logic                         reset,
	input  wire cpu_cfg_pkg::prog_write_t     prog,
	input  wire logic                         run,
	output logic [cpu_isa_pkg::PC_W-1:0]      pc,
	output cpu_cfg_pkg::out_word_t            result,
	output logic                              result_valid
);

	import cpu_isa_pkg::*;

	// fetched word
	instr_t instr;

	// register file traffic
	logic [REG_IDX_W-1:0] addr_a;
	logic [REG_IDX_W-1:0] addr_b;
	logic                 write_en;
	logic [DATA_W-1:0]    write_data;
	logic [DATA_W-1:0]    data_a;
	logic [DATA_W-1:0]    data_b;

	// alu outputs
	logic [DATA_W-1:0]    alu_result;
	logic                 alu_zero;

	prog_mem prog_mem_inst (
		.clk   (clk),
		.prog  (prog),
		.pc    (pc),
		.instr (instr)
	);

	cpu_core cpu_core_inst (
		.clk          (clk),
		.reset        (reset),
		.run          (run),
		.instr        (instr),
		.data_a       (data_a),
		.data_b       (data_b),
		.alu_result   (alu_result),
		.alu_zero     (alu_zero),
		.pc           (pc),
		.addr_a       (addr_a),
		.addr_b       (addr_b),
		.write_en     (write_en),
		.write_data   (write_data),
		.result       (result),
		.result_valid (result_valid)
	);

	cpu_regfile cpu_regfile_inst (
		.clk        (clk),
		.reset      (reset),
		.addr_a     (addr_a),
		.addr_b     (addr_b),
		.write_en   (write_en),
		.write_data (write_data),
		.data_a     (data_a),
		.data_b     (data_b)
	);

	cpu_alu cpu_alu_inst (
		.instr      (instr),
		.data_a     (data_a),
		.data_b     (data_b),
		.alu_result (alu_result),
		.alu_zero   (alu_zero)
	);

endmodule

`default_nettype wire

// File: verif/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
	input  wire logic                         clk,
	input  wire logic                         reset,
	input  wire cpu_cfg_pkg::prog_write_t     prog,
	input  wire logic                         run,
	input  wire logic [cpu_isa_pkg::PC_W-1:0] pc,
	input  wire cpu_cfg_pkg::out_word_t       result,
	input  wire logic                         result_valid,
	output int                                checks,
	output int                                errors
);

	import cpu_isa_pkg::*;
	import cpu_cfg_pkg::*;

	localparam int NUM_REGS = 2 ** REG_IDX_W;

	// model copy of the program filled by snooping the load port
	instr_t            m_mem [ROM_DEPTH];
	// architectural state of the model
	logic [DATA_W-1:0] m_regs [NUM_REGS];
	logic [PC_W-1:0]   m_pc;
	logic              m_zero;
	out_word_t         m_result;
	// out executed on the last edge
	logic              m_valid = 1'b0;
	int                step_cnt = 0;
	logic              in_reset = 1'b1;
	int                n_checks = 0;
	int                n_errors = 0;

	assign checks = n_checks;
	assign errors = n_errors;

	// executes the word at m_pc by the ISA rules
	function automatic void model_step();
		instr_t            ins;
		logic [DATA_W-1:0] imm;
		logic [DATA_W-1:0] va;
		logic [DATA_W-1:0] vb;
		logic [DATA_W-1:0] diff;
		logic [PC_W-1:0]   next_pc;
		ins = m_mem[m_pc];
		imm = {8'h00, ins.ri.imm};
		va = m_regs[ins.rr.reg_a];
		vb = m_regs[ins.rr.reg_b];
		// default flow wraps past the last word
		next_pc = m_pc + 1'b1;
		case (ins.rr.opcode)
			OP_LOAD: m_regs[ins.rr.reg_a] = imm;
			OP_ADD:  m_regs[ins.rr.reg_a] = va + vb;
			OP_ADDI: m_regs[ins.rr.reg_a] = va + imm;
			OP_SUB: begin
				diff = va - vb;
				m_regs[ins.rr.reg_a] = diff;
				m_zero = (diff == 16'h0000);
			end
			OP_SUBI: begin
				diff = va - imm;
				m_regs[ins.rr.reg_a] = diff;
				m_zero = (diff == 16'h0000);
			end
			OP_MOV:  m_regs[ins.rr.reg_a] = vb;
			OP_JMP:  next_pc = ins.jmp.target;
			OP_BR: begin
				if (m_zero) begin
					next_pc = ins.jmp.target;
				end
			end
			OP_OUT: begin
				// pc of the out itself, pad, low byte
				m_result = {m_pc, 4'h0, va[7:0]};
				m_valid = 1'b1;
			end
			default: ;
		endcase
		m_pc = next_pc;
	endfunction

	// inputs are driven on the falling edge and sampled here
	always @(posedge clk) begin
		if (prog.we) begin
			m_mem[prog.addr] = prog.data;
		end
		in_reset = reset;
		m_valid = 1'b0;
		if (reset) begin
			m_pc = '0;
			m_zero = 1'b0;
			m_result = '0;
			step_cnt = 0;
			for (int i = 0; i < NUM_REGS; i++) begin
				m_regs[i] = '0;
			end
		end else if (!run) begin
			// divider held while stopped
			step_cnt = 0;
		end else if (step_cnt == STEP_CYCLES - 1) begin
			step_cnt = 0;
			model_step();
		end else begin
			step_cnt++;
		end
	end

	// DUT outputs are stable mid cycle
	always @(negedge clk) begin
		if (!in_reset) begin
			n_checks++;
			if (pc !== m_pc) begin
				n_errors++;
				$display("[FAIL] %0t: pc expected %0d, got %0d", $time, m_pc, pc);
			end
			if (m_valid && result_valid !== 1'b1) begin
				n_errors++;
				$display("%0t: out at pc %0d gave no result_valid pulse", $time, m_result.pc);
			end else if (!m_valid && result_valid !== 1'b0) begin
				n_errors++;
				$display("%0t: result_valid pulsed although no out executed", $time);
			end
			// result holds between outs and is compared every cycle
			if (result !== m_result) begin
				n_errors++;
				$display("[FAIL] %0t: result expected %h, got %h", $time, m_result, result);
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

	import cpu_isa_pkg::*;
	import cpu_cfg_pkg::*;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_TESTS    = 13;

	logic            clk;
	logic            reset;
	logic            run;
	prog_write_t     prog;
	logic [PC_W-1:0] pc;
	out_word_t       result;
	logic            result_valid;
	int              checks;
	int              errors;

	// program image for the next test
	instr_t program_words [ROM_DEPTH];
	// steps per test, also sizes the watchdog
	int     test_steps [NUM_TESTS] = '{10, 14, 24, 20, 6, 40, 40, 40, 40, 40, 40, 40, 40};
	int     seed = 32'hb03a2462;
	int     failed_tests = 0;
	int     checks_before;
	int     errors_before;

	cpu_top cpu_top_inst (
		.clk          (clk),
		.reset        (reset),
		.prog         (prog),
		.run          (run),
		.pc           (pc),
		.result       (result),
		.result_valid (result_valid)
	);

	cpu_checker cpu_checker_inst (
		.clk          (clk),
		.reset        (reset),
		.prog         (prog),
		.run          (run),
		.pc           (pc),
		.result       (result),
		.result_valid (result_valid),
		.checks       (checks),
		.errors       (errors)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// instruction assembly
	function automatic instr_t reg_form(logic [OP_W-1:0] op, int a, int b);
		instr_t w;
		w = '0;
		w.rr.opcode = op;
		w.rr.reg_a = REG_IDX_W'(a);
		w.rr.reg_b = REG_IDX_W'(b);
		return w;
	endfunction

	function automatic instr_t imm_form(logic [OP_W-1:0] op, int a, logic [7:0] imm);
		instr_t w;
		w = '0;
		w.ri.opcode = op;
		w.ri.reg_a = REG_IDX_W'(a);
		w.ri.imm = imm;
		return w;
	endfunction

	function automatic instr_t jump_form(logic [OP_W-1:0] op, int target);
		instr_t w;
		w = '0;
		w.jmp.opcode = op;
		w.jmp.target = PC_W'(target);
		return w;
	endfunction

	// opcode 0 is a no-op, the rest of the word tracks the address
	task automatic clear_program();
		for (int i = 0; i < ROM_DEPTH; i++) begin
			program_words[i] = {4'h0, 8'(i * 17), 4'(i)};
		end
	endtask

	// stop, reset, then write all 16 words
	task automatic begin_test();
		checks_before = checks;
		errors_before = errors;
		@(negedge clk);
		run = 1'b0;
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < ROM_DEPTH; i++) begin
			@(negedge clk);
			prog.we = 1'b1;
			prog.addr = PC_W'(i);
			prog.data = program_words[i];
		end
		@(negedge clk);
		prog = '0;
	endtask

	// n rising edges see run high
	task automatic run_cycles(int n);
		@(negedge clk);
		run = 1'b1;
		repeat (n) @(negedge clk);
		run = 0;
	endtask

	task automatic end_test(string name);
		int    errs;
		string verdict;
		// idle with run low, pc must hold
		repeat (4) @(negedge clk);
		// counters move on the falling edge only
		@(posedge clk);
		errs = errors - errors_before;
		verdict = (errs == 0) ? "ok" : "failed";
		if (errs != 0) begin
			failed_tests++;
		end
		$display("test %s: %s, %0d checks, %0d errors", name, verdict,
			checks - checks_before, errs);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		run = 1'b0;
		prog = '0;

		// load, mov, out
		clear_program();
		program_words[0] = imm_form(OP_LOAD, 1, 8'h5a);
		program_words[1] = imm_form(OP_LOAD, 2, 8'hc3);
		program_words[2] = reg_form(OP_MOV, 3, 1);
		program_words[3] = reg_form(OP_MOV, 7, 2);
		program_words[4] = reg_form(OP_OUT, 3, 0);
		program_words[5] = reg_form(OP_OUT, 7, 0);
		program_words[6] = reg_form(OP_OUT, 2, 0);
		program_words[7] = reg_form(OP_OUT, 0, 0);
		begin_test();
		run_cycles(test_steps[0] * STEP_CYCLES);
		end_test("load_mov_out");

		// arithmetic with 16-bit wraparound
		clear_program();
		program_words[0] = imm_form(OP_LOAD, 3, 8'h00);
		program_words[1] = imm_form(OP_SUBI, 3, 8'h01);
		program_words[2] = reg_form(OP_OUT, 3, 0);
		program_words[3] = imm_form(OP_LOAD, 5, 8'h01);
		program_words[4] = reg_form(OP_ADD, 3, 5);
		program_words[5] = reg_form(OP_OUT, 3, 0);
		program_words[6] = imm_form(OP_ADDI, 5, 8'hfe);
		program_words[7] = reg_form(OP_SUB, 3, 5);
		program_words[8] = reg_form(OP_OUT, 3, 0);
		program_words[9] = imm_form(OP_ADDI, 3, 8'hff);
		program_words[10] = reg_form(OP_OUT, 3, 0);
		begin_test();
		run_cycles(test_steps[1] * STEP_CYCLES);
		end_test("arithmetic");

		// zero flag: taken, not taken, add leaves it alone
		clear_program();
		program_words[0] = imm_form(OP_LOAD, 1, 8'h05);
		program_words[1] = imm_form(OP_SUBI, 1, 8'h05);
		program_words[2] = jump_form(OP_BR, 4);
		program_words[3] = reg_form(OP_OUT, 1, 0);
		program_words[4] = imm_form(OP_SUBI, 1, 8'h01);
		program_words[5] = jump_form(OP_BR, 3);
		program_words[6] = reg_form(OP_ADD, 2, 0);
		program_words[7] = jump_form(OP_BR, 3);
		program_words[8] = reg_form(OP_OUT, 1, 0);
		program_words[9] = jump_form(OP_JMP, 0);
		begin_test();
		run_cycles(test_steps[2] * STEP_CYCLES);
		end_test("zero_branch");

		// jump forward, then run off the end and wrap
		clear_program();
		program_words[0] = imm_form(OP_LOAD, 1, 8'h01);
		program_words[1] = jump_form(OP_JMP, 13);
		program_words[2] = reg_form(OP_OUT, 1, 0);
		program_words[13] = imm_form(OP_ADDI, 1, 8'h01);
		program_words[14] = reg_form(OP_OUT, 1, 0);
		begin_test();
		run_cycles(test_steps[3] * STEP_CYCLES);
		end_test("jump_wrap");

		// run drops mid step, divider restarts
		clear_program();
		for (int i = 0; i < ROM_DEPTH; i++) begin
			program_words[i] = (i % 2 == 0) ? imm_form(OP_ADDI, 0, 8'h01) : reg_form(OP_OUT, 0, 0);
		end
		begin_test();
		run_cycles(10);
		repeat (10) @(negedge clk);
		run_cycles(14);
		end_test("cadence_reset");

		// random programs
		for (int t = 0; t < 8; t++) begin
			for (int i = 0; i < ROM_DEPTH; i++) begin
				program_words[i] = 16'($random(seed));
			end
			begin_test();
			run_cycles(test_steps[5 + t] * STEP_CYCLES);
			end_test($sformatf("random_%0d", t));
		end

		$display("total: %0d checks, %0d errors, %0d tests failed", checks, errors, failed_tests);
		if (errors == 0 && failed_tests == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// watchdog, twice the nominal length of all tests
	initial begin
		longint limit_ns;
		limit_ns = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			limit_ns += (ROM_DEPTH + test_steps[t]) * STEP_CYCLES * CLK_PERIOD;
		end
		limit_ns = 2 * limit_ns;
		#(limit_ns);
		$display("timeout: the test sequence did not finish within %0d ns", limit_ns);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
src/cpu_isa_pkg.sv
src/cpu_cfg_pkg.sv
src/prog_mem.sv
src/cpu_regfile.sv
src/cpu_alu.sv
src/cpu_core.sv
src/cpu_top.sv
verif/cpu_checker.sv
verif/cpu_tb.sv

// File: Bender.yml
package:
  name: cpu16

sources:
  - src/cpu_isa_pkg.sv
  - src/cpu_cfg_pkg.sv
  - src/prog_mem.sv
  - src/cpu_regfile.sv
  - src/cpu_alu.sv
  - src/cpu_core.sv
  - src/cpu_top.sv
  - target: test
    files:
      - verif/cpu_checker.sv
      - verif/cpu_tb.sv
